//--- src/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [7:0] wordT;                  // One data byte

    typedef enum logic [7:0] {
        opHalt = 8'h00,                         // Stop execution
        opInc  = 8'h01,                         // Unary, one operand
        opDec  = 8'h02,
        opNot  = 8'h03,
        opJump = 8'h04,                         // Relative, offset after the opcode
        opAdd  = 8'h10,                         // Binary, two operands
        opSub  = 8'h20,
        opMul  = 8'h30,
        opDiv  = 8'h40,
        opMod  = 8'h50,
        opAnd  = 8'h60,
        opOr   = 8'h70,
        opXor  = 8'h80,
        opNand = 8'h90,
        opNor  = 8'hA0,
        opXnor = 8'hB0
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluMul, aluDiv, aluMod, aluAnd,
        aluOr, aluXor, aluNand, aluNor, aluXnor, aluNotA
    } aluOpT;

    typedef enum logic [1:0] {busIr, busB, busC} busSelT;

    typedef struct packed {
        logic   irLoad;                         // IR from program memory
        logic   aLoad;                          // A from program memory
        logic   bLoad;                          // B from program memory
        logic   bLoadOne;                       // B gets constant one
        logic   cLoad;                          // C from ALU
        logic   pcInc;
        logic   pcJump;                         // PC plus B
        aluOpT  aluOp;
        busSelT busSel;                         // What the answer bus shows
    } ctrlT;

    typedef struct packed {
        wordT index;                            // Running answer number
        wordT data;
    } answerT;

endpackage

`default_nettype wire

//--- src/programStore.sv
`timescale 1ns/1ps
`default_nettype none

module programStore #(
    parameter int ProgDepth = 128
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         loadStrobe,
    input  wire cpuPkg::wordT                 loadData,
    input  wire logic [$clog2(ProgDepth)-1:0] pcAddr,
    output cpuPkg::wordT                      readData,
    output logic                              loaded
);
    import cpuPkg::*;

    localparam int AddrW = $clog2(ProgDepth);

    wordT             mem [ProgDepth];          // Program image
    logic [AddrW-1:0] loadCount;                // Next write address
    logic             writeEn;

    assign writeEn = loadStrobe && !loaded;     // Strobes after the last byte are dropped

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            loadCount <= '0;
            loaded    <= 1'b0;
        end else if (writeEn) begin
            loadCount <= loadCount + 1'b1;      // Wraps to zero on the last byte
            if (loadCount == AddrW'(ProgDepth - 1)) begin
                loaded <= 1'b1;                 // Held until reset
            end
        end
    end

    always_ff @(posedge clock) begin
        if (writeEn) begin
            mem[loadCount] <= loadData;
        end
    end

    // Read port runs every cycle, one cycle behind pcAddr
    always_ff @(posedge clock) begin
        readData <= mem[pcAddr];
    end

endmodule

`default_nettype wire

//--- src/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         loaded,
    input  wire cpuPkg::wordT ir,
    output cpuPkg::ctrlT      ctrl,
    output logic              emit,
    output logic              halted
);
    import cpuPkg::*;

    typedef enum logic [3:0] {
        sIdle, sFetch, sDecode, sReadA, sLoadA, sReadB,
        sLoadB, sJump, sExecute, sAnswerOp, sAnswerResult, sHalt
    } stateT;

    stateT  state;
    stateT  nextState;
    opcodeT opcode;

    assign opcode = opcodeT'(ir);
    assign halted = (state == sHalt);           // Sticky, only reset leaves sHalt

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            sIdle:         nextState = loaded ? sFetch : sIdle;  // Hold until image is in
            sFetch:        nextState = sDecode;
            sDecode:       nextState = sReadA;
            sReadA: begin                       // IR valid here, operand read in flight
                case (opcode)
                    opInc, opDec, opNot:        nextState = sLoadA;
                    opAdd, opSub, opMul, opDiv: nextState = sLoadA;
                    opMod, opAnd, opOr, opXor:  nextState = sLoadA;
                    opNand, opNor, opXnor:      nextState = sLoadA;
                    opJump:                     nextState = sLoadB;  // Offset only
                    default:                    nextState = sHalt;   // Halt and unknown
                endcase
            end
            sLoadA: begin
                if (opcode inside {opInc, opDec, opNot}) begin
                    nextState = sExecute;
                end else begin
                    nextState = sReadB;
                end
            end
            sReadB:        nextState = sLoadB;
            sLoadB:        nextState = (opcode == opJump) ? sJump : sExecute;
            sJump:         nextState = sAnswerOp;
            sExecute:      nextState = sAnswerOp;
            sAnswerOp:     nextState = sAnswerResult;
            sAnswerResult: nextState = sIdle;
            sHalt:         nextState = sHalt;
            default:       nextState = sIdle;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.aluOp  = aluAdd;
        ctrl.busSel = busIr;
        emit        = 1'b0;
        case (state)
            sDecode: begin
                ctrl.irLoad = 1'b1;             // Opcode byte into IR
                ctrl.pcInc  = 1'b1;
            end
            sLoadA: begin
                ctrl.aLoad    = 1'b1;
                ctrl.pcInc    = 1'b1;
                ctrl.bLoadOne = (opcode == opInc) || (opcode == opDec);  // Step of one
            end
            sLoadB: begin
                ctrl.bLoad = 1'b1;
                ctrl.pcInc = 1'b1;              // PC now past the operand
            end
            sJump:     ctrl.pcJump = 1'b1;      // Offset relative to next byte
            sExecute: begin
                ctrl.cLoad = 1'b1;
                case (opcode)
                    opDec, opSub: ctrl.aluOp = aluSub;
                    opNot:        ctrl.aluOp = aluNotA;
                    opMul:        ctrl.aluOp = aluMul;
                    opDiv:        ctrl.aluOp = aluDiv;
                    opMod:        ctrl.aluOp = aluMod;
                    opAnd:        ctrl.aluOp = aluAnd;
                    opOr:         ctrl.aluOp = aluOr;
                    opXor:        ctrl.aluOp = aluXor;
                    opNand:       ctrl.aluOp = aluNand;
                    opNor:        ctrl.aluOp = aluNor;
                    opXnor:       ctrl.aluOp = aluXnor;
                    default:      ctrl.aluOp = aluAdd;  // Inc and add
                endcase
            end
            sAnswerOp: begin
                ctrl.busSel = busIr;            // Opcode first
                emit        = 1'b1;
            end
            sAnswerResult: begin
                ctrl.busSel = (opcode == opJump) ? busB : busC;  // Jump reports its offset
                emit        = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpuPkg::wordT  a,
    input  wire cpuPkg::wordT  b,
    input  wire cpuPkg::aluOpT op,
    output cpuPkg::wordT       result
);
    import cpuPkg::*;

    wordT        product;                       // Low byte of the product
    logic        divByZero;
    wordT        quotient;
    wordT        remainder;

    assign product   = a * b;
    assign divByZero = (b == 8'h00);
    assign quotient  = divByZero ? 8'hFF : a / b;   // Error marker on zero divisor
    assign remainder = divByZero ? 8'hFF : a % b;

    always_comb begin
        case (op)
            aluAdd:  result = a + b;            // Wraps at 8 bits
            aluSub:  result = a - b;
            aluMul:  result = product;
            aluDiv:  result = quotient;
            aluMod:  result = remainder;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluNand: result = ~(a & b);
            aluNor:  result = ~(a | b);
            aluXnor: result = ~(a ^ b);
            aluNotA: result = ~a;               // B ignored
            default: result = a;
        endcase
    end

endmodule

`default_nettype wire

//--- src/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath #(
    parameter int ProgDepth = 128
) (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire cpuPkg::ctrlT           ctrl,
    input  wire cpuPkg::wordT           readData,
    output logic [$clog2(ProgDepth)-1:0] pcAddr,
    output cpuPkg::wordT                ir,
    output cpuPkg::wordT                bus
);
    import cpuPkg::*;

    localparam int AddrW = $clog2(ProgDepth);

    logic [AddrW-1:0] pc;                       // Wraps modulo ProgDepth
    wordT             a;
    wordT             b;
    wordT             c;
    wordT             aluResult;

    assign pcAddr = pc;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc <= '0;
            ir <= '0;
            a  <= '0;
            b  <= '0;
            c  <= '0;
        end else begin
            if (ctrl.irLoad) ir <= readData;
            if (ctrl.aLoad)  a  <= readData;
            if (ctrl.bLoad) begin
                b <= readData;
            end else if (ctrl.bLoadOne) begin
                b <= 8'h01;                     // Step for inc and dec
            end
            if (ctrl.cLoad)  c  <= aluResult;
            if (ctrl.pcJump) begin
                pc <= pc + b[AddrW-1:0];        // Offset truncated to address width
            end else if (ctrl.pcInc) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_comb begin
        case (ctrl.busSel)
            busIr:   bus = ir;
            busB:    bus = b;
            busC:    bus = c;
            default: bus = '0;
        endcase
    end

    alu aluInst (
        .a      (a),
        .b      (b),
        .op     (ctrl.aluOp),
        .result (aluResult)
    );

endmodule

`default_nettype wire

//--- src/answerWriter.sv
`timescale 1ns/1ps
`default_nettype none

module answerWriter (
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         emit,
    input  wire cpuPkg::wordT bus,
    output cpuPkg::answerT    answer,
    output logic              answerValid
);
    import cpuPkg::*;

    wordT index;                                // Number of the next answer byte

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            index       <= '0;
            answer      <= '0;
            answerValid <= 1'b0;
        end else begin
            answerValid <= emit;                // One cycle behind emit
            if (emit) begin
                answer.index <= index;
                answer.data  <= bus;
                index        <= index + 8'd1;   // Wraps at 256
            end
        end
    end

endmodule

`default_nettype wire

//--- src/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
    parameter int ProgDepth = 128               // Power of two, 16 to 256
) (
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         loadStrobe,
    input  wire cpuPkg::wordT loadData,
    output cpuPkg::answerT    answer,
    output logic              answerValid,
    output logic              halted
);
    import cpuPkg::*;

    localparam int AddrW = $clog2(ProgDepth);

    logic [AddrW-1:0] pcAddr;
    wordT             readData;                 // Registered memory read
    wordT             ir;
    wordT             bus;                      // Answer source
    ctrlT             ctrl;
    logic             loaded;
    logic             emit;

    programStore #(.ProgDepth(ProgDepth)) programStoreInst (
        .clock      (clock),
        .reset      (reset),
        .loadStrobe (loadStrobe),
        .loadData   (loadData),
        .pcAddr     (pcAddr),
        .readData   (readData),
        .loaded     (loaded)
    );

    controlUnit controlUnitInst (
        .clock  (clock),
        .reset  (reset),
        .loaded (loaded),
        .ir     (ir),
        .ctrl   (ctrl),
        .emit   (emit),
        .halted (halted)
    );

    dataPath #(.ProgDepth(ProgDepth)) dataPathInst (
        .clock    (clock),
        .reset    (reset),
        .ctrl     (ctrl),
        .readData (readData),
        .pcAddr   (pcAddr),
        .ir       (ir),
        .bus      (bus)
    );

    answerWriter answerWriterInst (
        .clock       (clock),
        .reset       (reset),
        .emit        (emit),
        .bus         (bus),
        .answer      (answer),
        .answerValid (answerValid)
    );

endmodule

`default_nettype wire

//--- test/cpuModel.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

answerT expectedQ [$];                          // Answers still to arrive, oldest first

// Queue one answer byte and step the running number
function automatic void expectByte(inout wordT index, input wordT data);
    expectedQ.push_back({index, data});
    index = index + 8'd1;                       // Wraps at 256
endfunction

function automatic wordT binaryResult(input wordT op, input wordT a, input wordT b);
    logic [15:0] wide;
    wordT        r;
    wide = {8'h00, a} * {8'h00, b};
    case (op)
        8'h10:   r = a + b;
        8'h20:   r = a - b;
        8'h30:   r = wide[7:0];                 // Low product byte
        8'h40:   r = (b == 8'h00) ? 8'hFF : a / b;
        8'h50:   r = (b == 8'h00) ? 8'hFF : a % b;
        8'h60:   r = a & b;
        8'h70:   r = a | b;
        8'h80:   r = a ^ b;
        8'h90:   r = ~(a & b);
        8'hA0:   r = ~(a | b);
        default: r = ~(a ^ b);                  // Xnor
    endcase
    return r;
endfunction

// Walk the image from address zero and list every answer byte
function automatic void runModel();
    int   pc;
    int   steps;
    wordT op;
    wordT x;
    wordT y;
    wordT index;
    expectedQ.delete();
    pc    = 0;
    steps = 0;
    index = 8'h00;
    while (steps < 4 * ProgDepth) begin         // Guards against a looping image
        op = image[pc];
        pc = (pc + 1) % ProgDepth;
        steps++;
        if (op == 8'h01 || op == 8'h02 || op == 8'h03) begin
            x  = image[pc];
            pc = (pc + 1) % ProgDepth;
            case (op)
                8'h01:   y = x + 8'd1;
                8'h02:   y = x - 8'd1;
                default: y = ~x;
            endcase
            expectByte(index, op);
            expectByte(index, y);
        end else if (op == 8'h04) begin
            x  = image[pc];
            pc = (pc + 1 + x) % ProgDepth;      // Offset counts from the next byte
            expectByte(index, op);
            expectByte(index, x);               // Jump reports its offset
        end else if (op[3:0] == 4'h0 && op[7:4] >= 4'h1 && op[7:4] <= 4'hB) begin
            x  = image[pc];
            y  = image[(pc + 1) % ProgDepth];
            pc = (pc + 2) % ProgDepth;
            expectByte(index, op);
            expectByte(index, binaryResult(op, x, y));
        end else begin
            break;                              // Halt or unknown opcode
        end
    end
endfunction

`endif

//--- test/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
    import cpuPkg::*;

    localparam int ProgDepth   = 128;
    localparam int HaltTimeout = 4000;          // Cycles per program
    localparam int QuietCycles = 40;            // Window after halt

    logic   clock;
    logic   reset;
    logic   loadStrobe;
    wordT   loadData;
    answerT answer;
    logic   answerValid;
    logic   halted;

    wordT   image [ProgDepth];                  // Image under test
    int     fillPtr;
    integer seed;
    int     checkErrors;
    int     otherErrors;
    answerT wantAnswer;

    `include "cpuModel.svh"

    cpuTop #(.ProgDepth(ProgDepth)) dut (
        .clock       (clock),
        .reset       (reset),
        .loadStrobe  (loadStrobe),
        .loadData    (loadData),
        .answer      (answer),
        .answerValid (answerValid),
        .halted      (halted)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Answer monitor, sampled mid-cycle
    always @(negedge clock) begin
        if (reset && answerValid) begin
            expectAny: assert (expectedQ.size() > 0) else begin
                $display("ERROR at %0t: answer %0d with data %02h came when none was due",
                         $time, answer.index, answer.data);
                otherErrors++;
            end
            if (expectedQ.size() > 0) begin
                wantAnswer = expectedQ.pop_front();
                answerMatch: assert (answer === wantAnswer) else begin
                    $display("CHECK FAILED at %0t: answer %0d/%02h, expected %0d/%02h",
                             $time, answer.index, answer.data,
                             wantAnswer.index, wantAnswer.data);
                    checkErrors++;
                end
            end
        end
    end

    task automatic checkQuiet(input string phase);
        quietCheck: assert (!answerValid && !halted) else begin
            $display("CHECK FAILED at %0t: answerValid %b halted %b during %s",
                     $time, answerValid, halted, phase);
            checkErrors++;
        end
    endtask

    function automatic wordT randomByte();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic clearImage();
        foreach (image[k]) image[k] = 8'h00;    // Zero fill halts after the program
        fillPtr = 0;
    endtask

    task automatic putByte(input wordT value);
        image[fillPtr] = value;
        fillPtr++;
    endtask

    task automatic putUnary(input wordT op, input wordT operand);
        putByte(op);
        putByte(operand);
    endtask

    task automatic putBinary(input wordT op, input wordT a, input wordT b);
        putByte(op);
        putByte(a);
        putByte(b);
    endtask

    task automatic resetDut();
        reset      = 1'b0;
        loadStrobe = 1'b0;
        loadData   = 8'h00;
        repeat (10) begin
            @(negedge clock);
            checkQuiet("reset");
        end
        reset = 1'b1;
    endtask

    task automatic loadImage(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clock);
            checkQuiet("load");                 // Nothing runs before the last byte
            loadStrobe = 1'b1;
            loadData   = image[i];
        end
        @(negedge clock);
        loadStrobe = 1'b0;
        loadData   = 8'h00;
    endtask

    // Wait until halted and every expected answer has been seen
    task automatic waitForHalt(input string name);
        int cycles;
        cycles = 0;
        while (!(halted && expectedQ.size() == 0) && cycles < HaltTimeout) begin
            @(negedge clock);
            cycles++;
        end
        if (!(halted && expectedQ.size() == 0)) begin
            $display("TIMEOUT: the %s program did not halt with all answers in %0d cycles",
                     name, HaltTimeout);
            otherErrors++;
        end
    endtask

    task automatic watchHalted(input string name);
        repeat (QuietCycles) begin
            @(negedge clock);
            haltHeld: assert (halted) else begin
                $display("CHECK FAILED at %0t: halted dropped after the %s program",
                         $time, name);
                checkErrors++;
            end
        end
    endtask

    task automatic runProgram(input string name);
        resetDut();
        runModel();
        loadImage(ProgDepth);
        waitForHalt(name);
        watchHalted(name);                      // Stray answers trip the monitor
    endtask

    initial begin
        int i;
        reset       = 1'b0;
        loadStrobe  = 1'b0;
        loadData    = 8'h00;
        seed        = 64;
        checkErrors = 0;
        otherErrors = 0;
        expectedQ.delete();

        // Reset and half an image, nothing may start
        clearImage();
        for (i = 0; i < ProgDepth; i++) begin
            image[i] = randomByte();
        end
        resetDut();
        loadImage(ProgDepth / 2);
        repeat (20) begin
            @(negedge clock);
            checkQuiet("partial load");
        end

        // Unary with both edge operands
        clearImage();
        for (i = 1; i <= 3; i++) begin
            putUnary(wordT'(i), 8'hFF);
            putUnary(wordT'(i), 8'h00);
            putUnary(wordT'(i), randomByte());
            putUnary(wordT'(i), randomByte());
        end
        runProgram("unary");

        clearImage();
        for (i = 1; i <= 11; i++) begin
            putBinary(wordT'(i << 4), randomByte(), randomByte());
        end
        putBinary(8'h40, randomByte(), 8'h00);  // Divide by zero
        putBinary(8'h50, randomByte(), 8'h00);  // Modulo by zero
        runProgram("binary");

        clearImage();
        putUnary(8'h01, randomByte());
        putUnary(8'h04, 8'h03);                 // Skips the add
        putBinary(8'h10, 8'h22, 8'h33);
        putUnary(8'h02, randomByte());
        putUnary(8'h04, 8'h00);                 // Zero offset falls through
        putUnary(8'h04, 8'h02);
        putUnary(8'h03, 8'h5A);                 // Skipped
        putUnary(8'h03, randomByte());
        runProgram("jump");

        clearImage();
        putUnary(8'h01, randomByte());
        putByte(8'h00);
        putUnary(8'h02, randomByte());          // Past the halt
        runProgram("halt");

        clearImage();
        putBinary(8'h70, randomByte(), randomByte());
        putByte(8'hC0);                         // Compare was dropped, so unknown
        putUnary(8'h01, randomByte());
        runProgram("unknown opcode");

        $display("Errors: %0d failed checks, %0d other failures", checkErrors, otherErrors);
        if (checkErrors == 0 && otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+test
src/cpuPkg.sv
src/programStore.sv
src/controlUnit.sv
src/alu.sv
src/dataPath.sv
src/answerWriter.sv
src/cpuTop.sv
test/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpuTb -Mdir obj_dir -o cpuSim -f src.f
./obj_dir/cpuSim 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
